/* list.f */
+incdir+verilog
verilog/mem_stage_pkg.sv
verilog/pipe_reg.sv
verilog/store_align.sv
verilog/load_align.sv
verilog/wb_master.sv
verilog/mem_stage.sv
sim/wb_mem_model.sv
sim/tb_mem_stage.sv

/* Makefile */
# Verilator build and run of the memory stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_mem_stage
RTL_TOP   ?= mem_stage
FILELIST  ?= list.f
LOG       ?= sim.log
FAIL_MSG  := ** FAIL **
BIN       := obj_dir/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a crash or a fail line in the log both fail the target
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_mem_stage.sv */
// aligned accesses only, addresses stay inside the 16-doubleword memory model
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module tb_mem_stage import mem_stage_pkg::*; ();

    localparam logic [31:0] LFSR_SEED = 32'h73d9_c289;
    localparam int MEM_WORDS = 16;
    localparam int N_ALU     = 16;
    localparam int N_STORE   = 15;   // 8 + 4 + 2 + 1 lanes
    localparam int N_LOAD    = 29;
    localparam int N_FWD     = 16;   // producer and store pairs
    localparam int N_RAND    = 60;
    localparam int N_OPS     = N_ALU + N_STORE + N_LOAD + N_FWD + N_RAND;
    localparam int TIMEOUT_CYCLES = N_OPS * 12 + 100;

    typedef struct packed {
        logic               we;
        logic [`ADDR_W-1:0] adr;
        logic [`XLEN-1:0]   dat;
        logic [`SEL_W-1:0]  sel;
    } bus_exp_t;

    logic clk, rst;
    logic in_valid, in_ready, out_valid, out_ready, out_wen;
    logic [`XLEN-1:0] in_pc, in_alu, in_src2, out_pc, out_data;
    mem_op_t in_op;
    wb_src_t in_wb_src;
    logic [`REG_ID_W-1:0] in_rd, in_rs2, out_rd;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`ADDR_W-1:0] wb_adr;
    logic [`XLEN-1:0] wb_dat_w, wb_dat_r;
    logic [`SEL_W-1:0] wb_sel;

    logic [31:0] lfsr;
    logic bp_on;     // random out_ready
    logic last_hs;   // handshake seen on the last edge
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] ref_mem [MEM_WORDS];
    wb_result_t exp_res_q[$];
    bus_exp_t exp_bus_q[$];
    logic prev_valid, prev_wen;   // last predicted result, for the bypass
    logic [`REG_ID_W-1:0] prev_rd;
    logic [`XLEN-1:0] prev_data;
    int err_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int bus_count = 0;
    int mem_op_count = 0;

    mem_stage uut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_pc(in_pc), .in_op(in_op),
        .in_wb_src(in_wb_src), .in_rd(in_rd), .in_rs2(in_rs2), .in_alu(in_alu),
        .in_src2(in_src2),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_rd(out_rd),
        .out_wen(out_wen), .out_data(out_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    wb_mem_model #(.DEPTH(MEM_WORDS), .SEED(LFSR_SEED)) mem_model (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns
    end

    // ******************************
    // helpers
    // ******************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic is_load_op(input mem_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic is_store_op(input mem_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    function automatic int access_bytes(input mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // reference model, one call per instruction in program order
    task automatic predict(input mem_op_t op, input wb_src_t src, input logic [4:0] rd,
                           input logic [4:0] rs2, input logic [63:0] pc,
                           input logic [63:0] alu, input logic [63:0] src2);
        wb_result_t r;
        bus_exp_t b;
        int idx;
        int off;
        int n;
        logic [63:0] val;
        logic [63:0] mask;
        idx = int'(alu[6:3]);
        off = int'(alu[2:0]);
        n   = access_bytes(op);
        r.pc  = pc;
        r.rd  = rd;
        // stores, idle none/none and x0 targets never write
        r.wen = 1'b1;
        if (is_store_op(op) || rd == 5'd0) begin
            r.wen = 1'b0;
        end
        if (op == op_none && src == src_none) begin
            r.wen = 1'b0;
        end
        case (src)
            src_alu:  r.data = alu;
            src_link: r.data = pc + 64'd4;
            src_csr:  r.data = src2;
            default:  r.data = '0;
        endcase
        b = '0;
        b.adr = {alu[31:3], 3'b000};
        if (is_store_op(op)) begin
            // previous result bypasses the register file
            val = (prev_valid && prev_wen && prev_rd != '0 && prev_rd == rs2) ? prev_data : src2;
            b.we = 1'b1;
            for (int k = 0; k < n; k++) begin
                b.dat[(off + k) * 8 +: 8]      = val[k * 8 +: 8];
                b.sel[off + k]                 = 1'b1;
                ref_mem[idx][(off + k) * 8 +: 8] = val[k * 8 +: 8];
            end
            exp_bus_q.push_back(b);
        end else if (is_load_op(op)) begin
            b.sel = '1;
            exp_bus_q.push_back(b);
            val = ref_mem[idx] >> (off * 8);
            if (n < 8) begin
                mask = (64'd1 << (n * 8)) - 64'd1;
                val  = val & mask;
                if (op inside {op_lb, op_lh, op_lw} && val[n * 8 - 1]) begin
                    val = val | ~mask;   // sign fill
                end
            end
            r.data = val;
        end
        exp_res_q.push_back(r);
        prev_valid = 1'b1;
        prev_wen   = r.wen;
        prev_rd    = rd;
        prev_data  = r.data;
    endtask

    // inputs move 1 ns after the edge
    task automatic next_cycle();
        logic [63:0] r;
        @(posedge clk);
        last_hs = in_valid && in_ready;
        #1;
        r = rand_bits(1);
        out_ready = !bp_on || r[0];
    endtask

    task automatic send(input mem_op_t op, input wb_src_t src, input logic [4:0] rd,
                        input logic [4:0] rs2, input logic [63:0] alu,
                        input logic [63:0] src2);
        predict(op, src, rd, rs2, pc_next, alu, src2);
        if (is_load_op(op) || is_store_op(op)) begin
            mem_op_count++;
        end
        in_valid  = 1'b1;
        in_pc     = pc_next;
        in_op     = op;
        in_wb_src = src;
        in_rd     = rd;
        in_rs2    = rs2;
        in_alu    = alu;
        in_src2   = src2;
        pc_next   = pc_next + 64'd4;
        do begin
            next_cycle();
        end while (!last_hs);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_res_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        $display("test %-8s done at %0t ns, %0d errors", name, $time, err_count - start_err);
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic run_alu_test();
        int start_err;
        logic [4:0] rd;
        logic [63:0] a;
        logic [63:0] s;
        start_err = err_count;
        for (int i = 0; i < N_ALU; i++) begin
            rd = (i % 5 == 0) ? 5'd0 : 5'(rand_bits(5));   // some x0 targets
            a  = rand_bits(64);
            s  = rand_bits(64);
            send(op_none, wb_src_t'(2'(i)), rd, 5'(rand_bits(5)), a, s);
        end
        drain();
        report_test("alu", start_err);
    endtask

    task automatic run_store_test();
        mem_op_t ops [4];
        int start_err;
        int n;
        logic [63:0] d;
        start_err = err_count;
        ops = '{op_sb, op_sh, op_sw, op_sd};
        for (int s = 0; s < 4; s++) begin
            n = access_bytes(ops[s]);
            for (int off = 0; off < 8; off += n) begin
                d = rand_bits(64);
                send(ops[s], src_none, '0, '0, 64'((s + 2) * 8 + off), d);   // words 2..5
            end
        end
        drain();
        report_test("store", start_err);
    endtask

    task automatic run_load_test();
        mem_op_t ops [7];
        int start_err;
        int n;
        int word;
        logic [4:0] rd;
        start_err = err_count;
        ops = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
        for (int l = 0; l < 7; l++) begin
            n = access_bytes(ops[l]);
            for (int off = 0; off < 8; off += n) begin
                word = 2 + int'(rand_bits(2));   // the words just stored
                rd   = {4'(rand_bits(4)), 1'b1};
                send(ops[l], src_alu, rd, '0, 64'(word * 8 + off), '0);
            end
        end
        drain();
        report_test("load", start_err);
    endtask

    task automatic run_forward_test();
        int start_err;
        logic [4:0] rd;
        logic [63:0] a;
        logic [63:0] s;
        start_err = err_count;
        for (int p = 0; p < N_FWD / 2; p++) begin
            rd = 5'(rand_bits(4)) + 5'd1;
            a  = rand_bits(64);
            s  = rand_bits(64);
            if (p % 2 == 0) begin
                send(op_none, src_alu, rd, '0, a, s);
            end else begin
                send(op_ld, src_none, rd, '0, 64'((2 + p % 4) * 8), s);   // load as producer
            end
            send(op_sd, src_none, '0, rd, 64'((6 + p % 2) * 8), rand_bits(64));
        end
        drain();
        report_test("forward", start_err);
    endtask

    task automatic run_random_test();
        int start_err;
        mem_op_t op;
        wb_src_t src;
        logic [2:0] off;
        logic [4:0] rd;
        logic [4:0] rs2;
        logic [63:0] addr;
        logic [63:0] a;
        logic [63:0] s;
        start_err = err_count;
        for (int i = 0; i < N_RAND; i++) begin
            op   = mem_op_t'(4'(rand_bits(4) % 12));
            src  = wb_src_t'(2'(rand_bits(2)));
            rd   = 5'(rand_bits(3));   // small register range, frequent bypass hits
            rs2  = 5'(rand_bits(3));
            off  = 3'(rand_bits(3)) & ~3'(access_bytes(op) - 1);
            addr = {57'd0, 4'(rand_bits(4)), off};
            a    = rand_bits(64);
            s    = rand_bits(64);
            send(op, src, rd, rs2, (is_load_op(op) || is_store_op(op)) ? addr : a, s);
        end
        drain();
        report_test("random", start_err);
    endtask

    // ******************************
    // checkers
    // ******************************
    always @(posedge clk) begin : monitor
        wb_result_t e;
        bus_exp_t b;
        if (!rst && out_valid && out_ready) begin
            if (exp_res_q.size() == 0) begin
                err_count++;
                $display("at %0t ns a writeback came out with no instruction outstanding", $time);
            end else begin
                e = exp_res_q.pop_front();
                check_equal("out_pc", out_pc, e.pc);
                check_equal("out_rd", 64'(out_rd), 64'(e.rd));
                check_equal("out_wen", 64'(out_wen), 64'(e.wen));
                if (e.wen) begin
                    check_equal("out_data", out_data, e.data);
                end
            end
        end
        if (!rst && wb_cyc && wb_stb && wb_ack) begin   // end of a bus cycle
            bus_count++;
            if (exp_bus_q.size() == 0) begin
                err_count++;
                $display("at %0t ns a Wishbone cycle ran with no access outstanding", $time);
            end else begin
                b = exp_bus_q.pop_front();
                check_equal("wb_we", 64'(wb_we), 64'(b.we));
                check_equal("wb_adr", 64'(wb_adr), 64'(b.adr));
                check_equal("wb_sel", 64'(wb_sel), 64'(b.sel));
                if (b.we) begin
                    check_equal("wb_dat_w", wb_dat_w, b.dat);
                end
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !wb_cyc)
        else begin
            err_count++;
            $display("mismatch at %0t ns: out_valid or wb_cyc high after reset", $time);
        end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_pc, out_rd, out_wen, out_data}))
        else begin
            err_count++;
            $display("mismatch at %0t ns: held writeback changed or vanished", $time);
        end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
        else begin
            err_count++;
            $display("at %0t ns the memory acked outside a bus cycle", $time);
        end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ******************************
    // main sequence
    // ******************************
    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_op      = op_none;
        in_wb_src  = src_none;
        in_rd      = '0;
        in_rs2     = '0;
        in_alu     = '0;
        in_src2    = '0;
        out_ready  = 1'b1;
        lfsr       = LFSR_SEED;
        bp_on      = 1'b0;
        last_hs    = 1'b0;
        pc_next    = 64'h0000_0000_8000_0000;
        prev_valid = 1'b0;
        prev_wen   = 1'b0;
        prev_rd    = '0;
        prev_data  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem_model.mem[i];   // start image
        end

        run_alu_test();
        run_store_test();
        run_load_test();
        run_forward_test();
        bp_on = 1'b1;
        run_random_test();

        if (exp_bus_q.size() != 0) begin
            err_count++;
            $display("%0d memory accesses never reached the bus", exp_bus_q.size());
        end
        check_equal("bus cycles", 64'(bus_count), 64'(mem_op_count));   // none repeated
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_equal("memory word", mem_model.mem[i], ref_mem[i]);
        end

        $display("checks %0d, errors %0d, cycles %0d", check_count, err_count, cycle_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim/wb_mem_model.sv */
// simulation only, DEPTH doublewords that wrap on the low address bits, ack after 0 to 3 wait cycles
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module wb_mem_model #(
    parameter int unsigned DEPTH = 16,              // power of two
    parameter logic [31:0] SEED  = 32'h0000_0001    // ack delay stream
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [`ADDR_W-1:0] wb_adr,
    input  logic [`XLEN-1:0]   wb_dat_w,
    input  logic [`SEL_W-1:0]  wb_sel,
    output logic [`XLEN-1:0]   wb_dat_r,
    output logic               wb_ack
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [`XLEN-1:0] mem [DEPTH];
    logic [31:0]      lfsr;
    logic             waiting;    // delay already drawn for this cycle
    logic [1:0]       wait_cnt;
    logic [IDX_W-1:0] idx;

    assign idx = wb_adr[3 +: IDX_W];   // doubleword index

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // every word differs, pattern taken from the full index
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {(32'(i) * 32'h9e37_79b9) ^ 32'hffff_0000, ~(32'(i) * 32'h85eb_ca6b)};
        end
    end

    // ******************************
    // slave side
    // ******************************
    always @(posedge clk) begin : slave
        logic [1:0] delay;
        if (rst) begin
            lfsr     = SEED;
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            waiting  <= 1'b0;
            wait_cnt <= '0;
        end else if (wb_ack) begin
            wb_ack  <= 1'b0;   // master drops stb on this edge
            waiting <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!waiting) begin
                delay[0] = lfsr[0];   // one step per bit
                lfsr     = lfsr_next(lfsr);
                delay[1] = lfsr[0];
                lfsr     = lfsr_next(lfsr);
            end else begin
                delay = wait_cnt;
            end
            if (delay == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[idx];
                for (int b = 0; b < `SEL_W; b++) begin
                    if (wb_we && wb_sel[b]) begin
                        mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];   // merge selected lanes
                    end
                end
            end else begin
                waiting  <= 1'b1;
                wait_cnt <= delay - 2'd1;
            end
        end
    end

endmodule

/* verilog/mem_stage.sv */
// one memory access in flight, aligned accesses only, and store data forwarded from the last result
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage import mem_stage_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // from execute
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [`XLEN-1:0]     in_pc,
    input  mem_op_t              in_op,
    input  wb_src_t              in_wb_src,
    input  logic [`REG_ID_W-1:0] in_rd,
    input  logic [`REG_ID_W-1:0] in_rs2,
    input  logic [`XLEN-1:0]     in_alu,
    input  logic [`XLEN-1:0]     in_src2,
    // to writeback
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [`XLEN-1:0]     out_pc,
    output logic [`REG_ID_W-1:0] out_rd,
    output logic                 out_wen,
    output logic [`XLEN-1:0]     out_data,
    // wishbone
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [`ADDR_W-1:0]   wb_adr,
    output logic [`XLEN-1:0]     wb_dat_w,
    output logic [`SEL_W-1:0]    wb_sel,
    input  logic [`XLEN-1:0]     wb_dat_r,
    input  logic                 wb_ack
);

    stage_req_t        in_req, st_q;
    wb_result_t        res_d, res_q;
    logic              st_valid, st_take;
    logic              res_valid, res_ready;
    logic              st_is_load, st_is_store, st_is_mem;
    logic              acc_done, done, start, mem_ok;
    logic              fwd_seen, fwd_hit;
    logic [`XLEN-1:0]  store_src, st_wdata, rdata, load_data, wb_value;
    logic [`SEL_W-1:0] st_sel;
    logic              wen;

    assign in_req = '{pc: in_pc, op: in_op, wb_src: in_wb_src, rd: in_rd,
                      rs2: in_rs2, alu: in_alu, src2: in_src2};

    // ******************************
    // stage register
    // ******************************
    pipe_reg #(.payload_t(stage_req_t)) u_stage_reg (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_req),
        .out_valid(st_valid), .out_ready(st_take), .out_data(st_q)
    );

    assign st_is_load  = st_q.op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    assign st_is_store = st_q.op inside {op_sb, op_sh, op_sw, op_sd};
    assign st_is_mem   = st_is_load || st_is_store;

    // access finished, or no access needed
    assign mem_ok  = !st_is_mem || acc_done || done;
    assign st_take = mem_ok && res_ready;
    // done masks the gap between ack and acc_done
    assign start   = st_valid && st_is_mem && !acc_done && !done && !wb_cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_done <= 1'b0;
        end else if (st_valid && st_take) begin
            acc_done <= 1'b0;   // next instruction starts fresh
        end else if (done) begin
            acc_done <= 1'b1;   // parked until the output register frees
        end
    end

    // forward the last result into store data
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_seen <= 1'b0;
        end else if (res_valid && res_ready) begin
            fwd_seen <= 1'b1;
        end
    end

    assign fwd_hit   = fwd_seen && res_q.wen && res_q.rd != '0 && res_q.rd == st_q.rs2;
    assign store_src = fwd_hit ? res_q.data : st_q.src2;

    // ******************************
    // memory access
    // ******************************
    store_align u_store_align (
        .op(st_q.op), .offset(st_q.alu[2:0]), .src(store_src),
        .data(st_wdata), .sel(st_sel)
    );

    wb_master u_wb_master (
        .clk(clk), .rst(rst),
        .start(start), .write(st_is_store),
        .adr({st_q.alu[`ADDR_W-1:3], 3'b000}),   // doubleword address, lanes via sel
        .dat(st_wdata), .sel(st_sel), .rdata(rdata), .done(done),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    load_align u_load_align (
        .op(st_q.op), .offset(st_q.alu[2:0]), .word(rdata), .data(load_data)
    );

    // ******************************
    // writeback select
    // ******************************
    always_comb begin
        if (st_is_load) begin
            wb_value = load_data;   // load wins over wb_src
        end else begin
            case (st_q.wb_src)
                src_alu:  wb_value = st_q.alu;
                src_link: wb_value = st_q.pc + `XLEN'(4);
                src_csr:  wb_value = st_q.src2;
                default:  wb_value = '0;
            endcase
        end
    end

    assign wen = st_q.rd != '0 && (st_is_load || (!st_is_store && st_q.wb_src != src_none));

    assign res_valid = st_valid && mem_ok;
    assign res_d     = '{pc: st_q.pc, rd: st_q.rd, wen: wen, data: wb_value};

    pipe_reg #(.payload_t(wb_result_t)) u_out_reg (
        .clk(clk), .rst(rst),
        .in_valid(res_valid), .in_ready(res_ready), .in_data(res_d),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(res_q)
    );

    assign out_pc   = res_q.pc;
    assign out_rd   = res_q.rd;
    assign out_wen  = res_q.wen;
    assign out_data = res_q.data;

endmodule

/* verilog/wb_master.sv */
// Wishbone classic only, one transfer per start, no retry or error and no pipelined mode
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module wb_master (
    input  logic               clk,
    input  logic               rst,
    // request side
    input  logic               start,   // one cycle, only while idle
    input  logic               write,
    input  logic [`ADDR_W-1:0] adr,
    input  logic [`XLEN-1:0]   dat,
    input  logic [`SEL_W-1:0]  sel,
    output logic [`XLEN-1:0]   rdata,   // held until the next read
    output logic               done,
    // wishbone
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output logic [`ADDR_W-1:0] wb_adr,
    output logic [`XLEN-1:0]   wb_dat_w,
    output logic [`SEL_W-1:0]  wb_sel,
    input  logic [`XLEN-1:0]   wb_dat_r,
    input  logic               wb_ack
);

    typedef enum logic {st_idle, st_busy} state_t;

    state_t state;

    // ******************************
    // control FSM
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;   // pulse
            case (state)
                st_idle: if (start) begin
                    state  <= st_busy;
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                end
                st_busy: if (wb_ack) begin
                    state  <= st_idle;
                    wb_cyc <= 1'b0;   // both drop on the ack edge
                    wb_stb <= 1'b0;
                    done   <= 1'b1;
                end
            endcase
        end
    end

    // request latched at start, read data on ack
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            wb_we    <= write;
            wb_adr   <= adr;
            wb_dat_w <= dat;
            wb_sel   <= write ? sel : '1;   // reads take the whole word
        end
        if (state == st_busy && wb_ack && !wb_we) begin
            rdata <= wb_dat_r;
        end
    end

    // ******************************
    // checks
    // ******************************
    a_stb_held: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable({wb_we, wb_adr, wb_sel, wb_dat_w}))
        else $error("%0t wb_master: strobe dropped or request moved before ack", $time);

    // the stage must wait for done before the next request
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> state == st_idle)
        else $error("%0t wb_master: start while busy", $time);

endmodule

/* verilog/load_align.sv */
// assumes an aligned load, the low offset bits below the access size are ignored
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module load_align import mem_stage_pkg::*; (
    input  mem_op_t          op,
    input  logic [2:0]       offset,   // address bits 2..0
    input  logic [`XLEN-1:0] word,     // full read word from the bus
    output logic [`XLEN-1:0] data
);

    logic [7:0]  byte_v;
    logic [15:0] half_v;
    logic [31:0] word_v;

    // slices picked by lane
    assign byte_v = word[{offset, 3'b000} +: 8];
    assign half_v = word[{offset[2:1], 4'b0000} +: 16];   // bit 0 dropped
    assign word_v = word[{offset[2], 5'b00000} +: 32];

    always_comb begin
        case (op)
            // sign extended
            op_lb:  data = {{(`XLEN - 8){byte_v[7]}}, byte_v};
            op_lh:  data = {{(`XLEN - 16){half_v[15]}}, half_v};
            op_lw:  data = {{(`XLEN - 32){word_v[31]}}, word_v};
            op_ld:  data = word;
            // zero extended
            op_lbu: data = `XLEN'(byte_v);
            op_lhu: data = `XLEN'(half_v);
            op_lwu: data = `XLEN'(word_v);
            default: data = '0;   // stores and none
        endcase
    end

endmodule

/* verilog/store_align.sv */
// naturally aligned stores only, a misaligned offset is flagged and never split over two words
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module store_align import mem_stage_pkg::*; (
    input  mem_op_t           op,
    input  logic [2:0]        offset,   // address bits 2..0
    input  logic [`XLEN-1:0]  src,
    output logic [`XLEN-1:0]  data,
    output logic [`SEL_W-1:0] sel
);

    logic [`XLEN-1:0]  low_part;   // access slice at lane 0
    logic [`SEL_W-1:0] size_sel;   // selects at lane 0
    logic              misaligned;

    always_comb begin
        case (op)
            op_sb: begin
                low_part = `XLEN'(src[7:0]);
                size_sel = `SEL_W'(8'h01);
            end
            op_sh: begin
                low_part = `XLEN'(src[15:0]);
                size_sel = `SEL_W'(8'h03);
            end
            op_sw: begin
                low_part = `XLEN'(src[31:0]);
                size_sel = `SEL_W'(8'h0f);
            end
            op_sd: begin
                low_part = src;
                size_sel = '1;
            end
            default: begin   // loads and none
                low_part = '0;
                size_sel = '0;
            end
        endcase
        data = low_part << {offset, 3'b000};   // byte lane shift
        sel  = size_sel << offset;
    end

    // natural alignment per size
    always_comb begin
        case (op)
            op_sh:   misaligned = offset[0];
            op_sw:   misaligned = |offset[1:0];
            op_sd:   misaligned = |offset;
            default: misaligned = 1'b0;
        endcase
    end

    a_store_aligned: assert final (!misaligned)
        else $error("%0t store_align: %s at offset %0d", $time, op.name(), offset);

endmodule

/* verilog/pipe_reg.sv */
// single entry with no bypass of an empty slot, so every item costs at least one cycle
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;     // slot holds an item
    payload_t data_q;

    // free now, or freed by the consumer this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;   // drains when nothing new comes
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    // ******************************
    // checks
    // ******************************

    // held item keeps its payload until the consumer takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("%0t pipe_reg: payload changed while held", $time);

endmodule

/* verilog/mem_stage_pkg.sv */
// op and writeback encodings are fixed by the execute stage, keep them in step with it
`include "mem_stage_settings.svh"

package mem_stage_pkg;

    // memory op, already decoded upstream
    typedef enum logic [3:0] {
        op_none,
        op_lb, op_lh, op_lw, op_ld,   // signed loads
        op_lbu, op_lhu, op_lwu,       // zero-extended loads
        op_sb, op_sh, op_sw, op_sd    // stores
    } mem_op_t;

    // writeback source for non-load ops
    typedef enum logic [1:0] {
        src_none,
        src_alu,
        src_link,   // pc + 4
        src_csr     // old csr value rides in src2
    } wb_src_t;

    // stage register payload
    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        mem_op_t              op;
        wb_src_t              wb_src;
        logic [`REG_ID_W-1:0] rd;
        logic [`REG_ID_W-1:0] rs2;
        logic [`XLEN-1:0]     alu;    // result or effective address
        logic [`XLEN-1:0]     src2;   // store data or csr value
    } stage_req_t;

    // output register payload
    typedef struct packed {
        logic [`XLEN-1:0]     pc;
        logic [`REG_ID_W-1:0] rd;
        logic                 wen;
        logic [`XLEN-1:0]     data;
    } wb_result_t;

endpackage

/* verilog/mem_stage_settings.svh */
// RV64 only with a 32-bit byte address and eight byte lanes on a single Wishbone port
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// ******************************
// datapath widths
// ******************************
`define XLEN 64        // integer register and bus word width

// ******************************
// bus and register file
// ******************************
`define ADDR_W 32      // wishbone byte address
`define SEL_W 8        // one select per byte of XLEN
`define REG_ID_W 5     // x0..x31

`endif
